// ==== mouse_uart.f ====
source/mouse_uart_pkg.sv
source/packet_capture.sv
source/spart_driver.sv
source/baud_gen.sv
source/spart_tx.sv
source/spart.sv
source/mouse_uart_top.sv
tests/mouse_uart_assertions.sv
tests/tb_mouse_uart.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the mouse UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mouse_uart \
    -f mouse_uart.f -Mdir obj_dir -o sim_mouse_uart
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/sim_mouse_uart +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tests/tb_mouse_uart.sv ====
`timescale 1ns/1ns

module tb_mouse_uart;

    logic                          clk;
    logic                          rst;
    mouse_uart_pkg::br_cfg_t       br_cfg;
    mouse_uart_pkg::mouse_packet_t packet_in;
    logic                          packet_valid;
    logic                          txd;
    logic [1:0]                    status_bits;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    longint watchdog_ns;

    mouse_uart_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .br_cfg       (br_cfg),
        .packet_in    (packet_in),
        .packet_valid (packet_valid),
        .txd          (txd),
        .status_bits  (status_bits)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    // Clock cycles per serial bit for one baud selection
    function automatic int bit_cycles(input mouse_uart_pkg::br_cfg_t cfg);
        int div;
        case (cfg)
            2'd0:    div = mouse_uart_pkg::DIV_CFG0;
            2'd1:    div = mouse_uart_pkg::DIV_CFG1;
            2'd2:    div = mouse_uart_pkg::DIV_CFG2;
            default: div = mouse_uart_pkg::DIV_CFG3;
        endcase
        return mouse_uart_pkg::OVERSAMPLE * (div + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset(input mouse_uart_pkg::br_cfg_t cfg);
        @(posedge clk);
        rst    <= 1'b1;
        br_cfg <= cfg;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic random_packet(output mouse_uart_pkg::mouse_packet_t pkt);
        logic [31:0] r;
        r   = $random(seed);
        pkt = r[23:0];
    endtask

    task automatic send_packet(input mouse_uart_pkg::mouse_packet_t pkt);
        @(posedge clk);
        packet_in    <= pkt;
        packet_valid <= 1'b1;
        @(posedge clk);
        packet_valid <= 1'b0;
    endtask

    // Returned byte holds the first bit on the line as bit 7
    task automatic decode_frame(input int bt, output mouse_uart_pkg::byte_t line_byte,
                                output int len);
        int i;
        line_byte = '0;
        @(negedge txd);
        repeat (bt / 2) @(negedge clk);
        check_value("txd start bit", txd, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (bt) @(negedge clk);
            line_byte[7 - i] = txd;
        end
        repeat (bt) @(negedge clk);
        check_value("txd stop bit", txd, 1'b1);
        len = bt / 2 + 9 * bt;
        // Frame is over once the transmitter is free again
        while (i_dut.tbr !== 1'b1) begin
            @(negedge clk);
            len++;
        end
    endtask

    task automatic receive_packet(input mouse_uart_pkg::mouse_packet_t pkt, input int bt);
        mouse_uart_pkg::byte_t b;
        int                    len;
        decode_frame(bt, b, len);
        check_value("status frame", b, pkt.status);
        check_value("status_bits", status_bits, pkt.status[1:0]);
        decode_frame(bt, b, len);
        check_value("x frame", b, pkt.x);
        decode_frame(bt, b, len);
        check_value("y frame", b, pkt.y);
    endtask

    task automatic expect_idle(input int cycles, input string what);
        int n;
        int low;
        low = 0;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            low = low + int'(txd !== 1'b1);
        end
        checks++;
        assert (low == 0) else begin
            $display("txd went low %s, time %0t", what, $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic idle_after_reset();
        int e;
        e = errors;
        apply_reset(2'd3);
        repeat (2) @(negedge clk);
        check_value("txd", txd, 1'b1);
        check_value("status_bits", status_bits, 2'b00);
        expect_idle(10 * bit_cycles(2'd3), "with no packet");
        report_test("idle_after_reset", e);
    endtask

    task automatic single_packet();
        mouse_uart_pkg::mouse_packet_t pkt;
        int                            e;
        e = errors;
        random_packet(pkt);
        send_packet(pkt);
        receive_packet(pkt, bit_cycles(2'd3));
        report_test("single_packet", e);
    endtask

    task automatic baud_selection();
        mouse_uart_pkg::mouse_packet_t pkt;
        mouse_uart_pkg::byte_t         b;
        int                            len;
        int                            bt;
        int                            cfg;
        int                            e;
        e = errors;
        for (cfg = 0; cfg < 4; cfg++) begin
            bt = bit_cycles(cfg[1:0]);
            apply_reset(cfg[1:0]);
            random_packet(pkt);
            send_packet(pkt);
            decode_frame(bt, b, len);
            check_value("status frame", b, pkt.status);
            checks++;
            // Ten bits per frame, one cycle of slack per bit
            assert ((len + 5) / 10 >= bt - 1 && (len + 5) / 10 <= bt + 1) else begin
                $display("CHECK FAILED at %0t: bit_time got %0d expected %0d",
                         $time, (len + 5) / 10, bt);
                errors++;
            end
        end
        apply_reset(2'd3);
        report_test("baud_selection", e);
    endtask

    task automatic drop_while_busy();
        mouse_uart_pkg::mouse_packet_t first;
        mouse_uart_pkg::mouse_packet_t second;
        int                            e;
        e = errors;
        random_packet(first);
        random_packet(second);
        send_packet(first);
        repeat (3) @(posedge clk);
        // Holder is still full, so this one must vanish
        send_packet(second);
        receive_packet(first, bit_cycles(2'd3));
        expect_idle(20 * bit_cycles(2'd3), "after the dropped packet");
        report_test("drop_while_busy", e);
    endtask

    task automatic back_to_back();
        mouse_uart_pkg::mouse_packet_t first;
        mouse_uart_pkg::mouse_packet_t second;
        int                            e;
        e = errors;
        random_packet(first);
        random_packet(second);
        // Different buttons so the update is visible
        second.status[1:0] = ~first.status[1:0];
        send_packet(first);
        receive_packet(first, bit_cycles(2'd3));
        send_packet(second);
        receive_packet(second, bit_cycles(2'd3));
        report_test("back_to_back", e);
    endtask

    initial begin
        watchdog_ns = 10 * (15 * bit_cycles(2'd3) + bit_cycles(2'd0) + bit_cycles(2'd1)
                      + bit_cycles(2'd2) + bit_cycles(2'd3));
        // 20 ns clock, 20 % margin
        watchdog_ns = watchdog_ns * 20 * 12 / 10;
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns with tests still running", watchdog_ns);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed         = 32'hec28_30c0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        rst          = 1'b1;
        br_cfg       = 2'd3;
        packet_in    = '0;
        packet_valid = 1'b0;
        idle_after_reset();
        single_packet();
        baud_selection();
        drop_while_busy();
        back_to_back();
        checks++;
        assert (i_dut.i_assertions.failures == 0) else begin
            $display("Bound protocol assertions failed %0d times", i_dut.i_assertions.failures);
            errors++;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tests/mouse_uart_assertions.sv ====
`timescale 1ns/1ns

module mouse_uart_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       txd,
    input logic                       tbr,
    input mouse_uart_pkg::spart_bus_t bus,
    input logic                       dav,
    input logic                       packet_ack
);

    int failures = 0;

    // Line idles high while the transmit buffer is free
    assert property (@(posedge clk) disable iff (rst) tbr |-> txd) else begin
        $error("txd low while tbr is high");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst)
        (bus.write && bus.addr == mouse_uart_pkg::REG_TX_DATA) |-> tbr) else begin
        $error("transmit data written while tbr is low");
        failures++;
    end

    // Holder stays full until the driver takes the packet
    assert property (@(posedge clk) disable iff (rst) (dav && !packet_ack) |=> dav) else begin
        $error("dav dropped without packet_ack");
        failures++;
    end

endmodule

bind mouse_uart_top mouse_uart_assertions i_assertions (
    .clk(clk), .rst(rst), .txd(txd), .tbr(tbr), .bus(bus), .dav(dav), .packet_ack(packet_ack)
);

// ==== source/mouse_uart_top.sv ====
`timescale 1ns/1ns

module mouse_uart_top (
    input  logic                          clk,
    input  logic                          rst,
    input  mouse_uart_pkg::br_cfg_t       br_cfg,
    input  mouse_uart_pkg::mouse_packet_t packet_in,
    input  logic                          packet_valid,
    output logic                          txd,
    output logic [1:0]                    status_bits
);

    logic                          dav;
    logic                          packet_ack;
    logic                          tbr;
    mouse_uart_pkg::mouse_packet_t packet;
    mouse_uart_pkg::spart_bus_t    bus;

    packet_capture i_capture (
        .clk          (clk),
        .rst          (rst),
        .packet_in    (packet_in),
        .packet_valid (packet_valid),
        .packet_ack   (packet_ack),
        .dav          (dav),
        .packet       (packet)
    );

    spart_driver i_driver (
        .clk         (clk),
        .rst         (rst),
        .br_cfg      (br_cfg),
        .dav         (dav),
        .packet      (packet),
        .tbr         (tbr),
        .bus         (bus),
        .packet_ack  (packet_ack),
        .status_bits (status_bits)
    );

    spart i_spart (
        .clk (clk),
        .rst (rst),
        .bus (bus),
        .txd (txd),
        .tbr (tbr)
    );

endmodule

// ==== source/spart.sv ====
`timescale 1ns/1ns

module spart (
    input  logic                       clk,
    input  logic                       rst,
    input  mouse_uart_pkg::spart_bus_t bus,
    output logic                       txd,
    output logic                       tbr
);

    mouse_uart_pkg::divisor_t divisor_q;
    logic                     baud_en;
    logic                     tx_load;

    //////////////////////////////
    // Divisor registers
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            divisor_q <= '0;
        end else if (bus.write) begin
            case (bus.addr)
                mouse_uart_pkg::REG_DIV_LOW:  divisor_q[7:0]  <= bus.wdata;
                mouse_uart_pkg::REG_DIV_HIGH: divisor_q[15:8] <= bus.wdata;
                // Address 1 has no register behind it
                default: ;
            endcase
        end
    end

    assign tx_load = bus.write && (bus.addr == mouse_uart_pkg::REG_TX_DATA);

    baud_gen i_baud_gen (
        .clk     (clk),
        .rst     (rst),
        .divisor (divisor_q),
        .enable  (baud_en)
    );

    spart_tx i_spart_tx (
        .clk    (clk),
        .rst    (rst),
        .enable (baud_en),
        .load   (tx_load),
        .data   (bus.wdata),
        .txd    (txd),
        .tbr    (tbr)
    );

endmodule

// ==== source/spart_tx.sv ====
`timescale 1ns/1ns

module spart_tx (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  load,
    input  mouse_uart_pkg::byte_t data,
    output logic                  txd,
    output logic                  tbr
);

    localparam int OS_W = $clog2(mouse_uart_pkg::OVERSAMPLE);

    logic [8:0]      shift_q;
    logic            started;
    logic [OS_W-1:0] os_cnt;
    logic [3:0]      bit_cnt;
    logic            bit_end;

    assign bit_end = (os_cnt == OS_W'(mouse_uart_pkg::OVERSAMPLE - 1));

    //////////////////////////////
    // Frame sequencer
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd     <= 1'b1;
            tbr     <= 1'b1;
            started <= 1'b0;
            os_cnt  <= '0;
            bit_cnt <= '0;
            shift_q <= '1;
        end else if (load && tbr) begin
            // Stop bit rides above the data
            shift_q <= {1'b1, data};
            tbr     <= 1'b0;
            started <= 1'b0;
        end else if (!tbr && enable) begin
            if (!started) begin
                // Start bit lines up with a baud tick
                started <= 1'b1;
                txd     <= 1'b0;
                os_cnt  <= '0;
                bit_cnt <= '0;
            end else if (bit_end) begin
                os_cnt <= '0;
                if (bit_cnt == 4'(mouse_uart_pkg::FRAME_BITS - 1)) begin
                    tbr     <= 1'b1;
                    started <= 1'b0;
                    txd     <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    txd     <= shift_q[0];
                    shift_q <= {1'b1, shift_q[8:1]};
                end
            end else begin
                os_cnt <= os_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/baud_gen.sv ====
`timescale 1ns/1ns

module baud_gen (
    input  logic                     clk,
    input  logic                     rst,
    input  mouse_uart_pkg::divisor_t divisor,
    output logic                     enable
);

    mouse_uart_pkg::divisor_t count;
    mouse_uart_pkg::divisor_t div_q;
    logic                     div_changed;

    // A new divisor restarts the period from the top
    assign div_changed = (divisor != div_q);

    //////////////////////////////
    // Down-counter
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count  <= '0;
            div_q  <= '0;
            enable <= 1'b0;
        end else if (div_changed) begin
            div_q  <= divisor;
            count  <= divisor;
            enable <= 1'b0;
        end else if (count == '0) begin
            // One pulse every div_q+1 cycles
            count  <= div_q;
            enable <= 1'b1;
        end else begin
            count  <= count - 1'b1;
            enable <= 1'b0;
        end
    end

endmodule

// ==== source/spart_driver.sv ====
`timescale 1ns/1ns

module spart_driver (
    input  logic                          clk,
    input  logic                          rst,
    input  mouse_uart_pkg::br_cfg_t       br_cfg,
    input  logic                          dav,
    input  mouse_uart_pkg::mouse_packet_t packet,
    input  logic                          tbr,
    output mouse_uart_pkg::spart_bus_t    bus,
    output logic                          packet_ack,
    output logic [1:0]                    status_bits
);

    mouse_uart_pkg::driver_state_t state_q;
    mouse_uart_pkg::driver_state_t state_d;
    mouse_uart_pkg::divisor_t      div;
    mouse_uart_pkg::byte_t         status_q;
    logic                          status_write;

    assign div = mouse_uart_pkg::div_lookup(br_cfg);

    //////////////////////////////
    // State register
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= mouse_uart_pkg::load_low;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // Next state and bus
    //////////////////////////////
    always_comb begin
        state_d    = state_q;
        bus.write  = 1'b0;
        bus.addr   = mouse_uart_pkg::REG_TX_DATA;
        bus.wdata  = '0;
        packet_ack = 1'b0;

        unique case (state_q)
            mouse_uart_pkg::load_low: begin
                bus.write = 1'b1;
                bus.addr  = mouse_uart_pkg::REG_DIV_LOW;
                bus.wdata = div[7:0];
                state_d   = mouse_uart_pkg::load_high;
            end
            mouse_uart_pkg::load_high: begin
                bus.write = 1'b1;
                bus.addr  = mouse_uart_pkg::REG_DIV_HIGH;
                bus.wdata = div[15:8];
                state_d   = mouse_uart_pkg::wait_packet;
            end
            mouse_uart_pkg::wait_packet: begin
                if (dav) begin
                    state_d = mouse_uart_pkg::send_status;
                end
            end
            mouse_uart_pkg::send_status: begin
                if (tbr) begin
                    bus.write = 1'b1;
                    bus.wdata = mouse_uart_pkg::bit_reverse(packet.status);
                    state_d   = mouse_uart_pkg::send_x;
                end
            end
            mouse_uart_pkg::send_x: begin
                if (tbr) begin
                    bus.write = 1'b1;
                    bus.wdata = mouse_uart_pkg::bit_reverse(packet.x);
                    state_d   = mouse_uart_pkg::send_y;
                end
            end
            mouse_uart_pkg::send_y: begin
                if (tbr) begin
                    bus.write  = 1'b1;
                    bus.wdata  = mouse_uart_pkg::bit_reverse(packet.y);
                    // Last byte frees the capture block
                    packet_ack = 1'b1;
                    state_d    = mouse_uart_pkg::wait_packet;
                end
            end
            default: begin
                state_d = mouse_uart_pkg::wait_packet;
            end
        endcase
    end

    // Buttons latched as the status byte goes out
    assign status_write = (state_q == mouse_uart_pkg::send_status) && tbr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_q <= '0;
        end else if (status_write) begin
            status_q <= packet.status;
        end
    end

    assign status_bits = status_q[1:0];

endmodule

// ==== source/packet_capture.sv ====
`timescale 1ns/1ns

module packet_capture (
    input  logic                         clk,
    input  logic                         rst,
    input  mouse_uart_pkg::mouse_packet_t packet_in,
    input  logic                         packet_valid,
    input  logic                         packet_ack,
    output logic                         dav,
    output mouse_uart_pkg::mouse_packet_t packet
);

    logic take;

    // Only an empty holder accepts a new packet
    assign take = packet_valid && !dav;

    //////////////////////////////
    // Full flag
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dav <= 1'b0;
        end else if (packet_ack) begin
            dav <= 1'b0;
        end else if (take) begin
            dav <= 1'b1;
        end
    end

    // Packet payload
    always_ff @(posedge clk) begin
        if (take) begin
            packet <= packet_in;
        end
    end

endmodule

// ==== source/mouse_uart_pkg.sv ====
package mouse_uart_pkg;

    //////////////////////////////
    // Basic widths
    //////////////////////////////
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] divisor_t;
    typedef logic [1:0]  reg_addr_t;
    typedef logic [1:0]  br_cfg_t;
    typedef logic [1:0]  packet_idx_t;

    // Three-byte mouse report with the status byte first
    typedef struct packed {
        byte_t status;
        byte_t x;
        byte_t y;
    } mouse_packet_t;

    // One-way write bus into the SPART
    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        byte_t     wdata;
    } spart_bus_t;

    typedef enum logic [2:0] {
        load_low,
        load_high,
        wait_packet,
        send_status,
        send_x,
        send_y
    } driver_state_t;

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam reg_addr_t REG_TX_DATA  = 2'd0;
    localparam reg_addr_t REG_DIV_LOW  = 2'd2;
    localparam reg_addr_t REG_DIV_HIGH = 2'd3;

    // Divisor per baud selection
    localparam divisor_t DIV_CFG0 = 16'd1301;
    localparam divisor_t DIV_CFG1 = 16'd650;
    localparam divisor_t DIV_CFG2 = 16'd325;
    localparam divisor_t DIV_CFG3 = 16'd162;

    localparam int OVERSAMPLE = 16;
    // Start, eight data, stop
    localparam int FRAME_BITS = 10;

    function automatic divisor_t div_lookup(input br_cfg_t cfg);
        divisor_t div;
        case (cfg)
            2'd0:    div = DIV_CFG0;
            2'd1:    div = DIV_CFG1;
            2'd2:    div = DIV_CFG2;
            default: div = DIV_CFG3;
        endcase
        return div;
    endfunction

    // MSB ends up in bit 0
    function automatic byte_t bit_reverse(input byte_t b);
        byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

endpackage
